/* bench/raster_tb.sv */
// testbench for the line rasterizer
// drives commands, walks reference lines and checks the vram writes
`timescale 1ns/1ps

module raster_tb
    import raster_pkg::*;
();

    localparam int SEED       = 32'h5b09d2d5;
    localparam int TIMEOUT    = 40000;
    localparam int RAND_LINES = 20;

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    logic [CMD_W-1:0] cmd_data;
    logic             cmd_ready;
    vram_wr_t         vram;
    logic             swap;

    int                 errors;
    int                 swap_count;
    logic [ADDR_W-1:0]  exp_addr [$];
    logic [PIXEL_W-1:0] exp_data [$];

    raster_top raster_top_i (
        .clk               (clk),
        .reset_i           (reset),
        .cmd_axis_tvalid_i (cmd_valid),
        .cmd_axis_tready_o (cmd_ready),
        .cmd_axis_tdata_i  (cmd_data),
        .vram_o            (vram),
        .swap_o            (swap)
    );

    vram_model vram_model_i (
        .clk    (clk),
        .vram_i (vram)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            swap_count <= 0;
        end else if (swap) begin
            swap_count <= swap_count + 1;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // swap is a single pulse and never overlaps a write
    a_swap_pulse: assert property (@(posedge clk) disable iff (reset) swap |=> !swap)
        else log_error("swap_o high for more than one cycle");
    a_swap_quiet: assert property (@(posedge clk) disable iff (reset) swap |-> !vram.wr)
        else log_error("vram write during swap");

    task automatic abort_run(input string what);
        $display("timeout: %s did not finish", what);
        $display("errors: %0d", errors);
        $display("sim failed");
        $finish;
    endtask

    function automatic logic [CMD_W-1:0] cmd_word(input logic [OP_W-1:0] op, input int value);
        cmd_word                     = '0;
        cmd_word[OP_POS +: OP_W]     = op;
        cmd_word[PAYLOAD_W-1:0]      = value[PAYLOAD_W-1:0];
    endfunction

    // valid stays high on return, so commands can follow back to back
    task automatic send_cmd(input logic [CMD_W-1:0] word, input string what);
        int waited;
        waited    = 0;
        cmd_valid <= 1'b1;
        cmd_data  <= word;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run({what, " command handshake"});
            end
        end while (!cmd_ready);
    endtask

    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run({what, " command"});
            end
        end while (!cmd_ready);
    endtask

    // register, swap and ignored commands: one cycle busy and no writes
    task automatic check_short_cmd(input logic [CMD_W-1:0] word, input logic exp_swap,
                                   input string what);
        int base;
        int swaps;
        base  = vram_model_i.log_addr.size();
        swaps = swap_count;
        send_cmd(word, what);
        cmd_valid <= 1'b0;
        @(posedge clk);
        assert (!cmd_ready) else log_error({what, ": ready high right after acceptance"});
        assert (swap == exp_swap) else log_error({what, ": wrong swap_o in the exec cycle"});
        @(posedge clk);
        assert (cmd_ready) else log_error({what, ": ready low for more than one cycle"});
        assert (!swap) else log_error({what, ": swap_o high one cycle late"});
        @(negedge clk);
        assert (vram_model_i.log_addr.size() == base)
            else log_error({what, ": unexpected vram write"});
        assert (swap_count == swaps + int'(exp_swap))
            else log_error({what, ": wrong number of swap pulses"});
        @(posedge clk);
    endtask

    // bresenham walk with the same clipping, appended to the expected log
    task automatic walk_ref(input int x0, input int y0, input int x1, input int y1,
                            input logic [PIXEL_W-1:0] color);
        int x, y, dx, dy, sx, sy, err, e2, steps;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        for (steps = 0; steps < 1024; steps++) begin
            if (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT) begin
                exp_addr.push_back(ADDR_W'(y * FB_WIDTH + x));
                exp_data.push_back(color);
            end
            if (x == x1 && y == y1) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endtask

    task automatic queue_line(input int x0, input int y0, input int x1, input int y1,
                              input logic [PIXEL_W-1:0] color);
        walk_ref(x0, y0, x1, y1, color);
        send_cmd(cmd_word(OP_SET_COLOR, int'(color)), "set color");
        send_cmd(cmd_word(OP_SET_X0, x0), "set x0");
        send_cmd(cmd_word(OP_SET_Y0, y0), "set y0");
        send_cmd(cmd_word(OP_SET_X1, x1), "set x1");
        send_cmd(cmd_word(OP_SET_Y1, y1), "set y1");
        send_cmd(cmd_word(OP_DRAW_LINE, 0), "draw line");
    endtask

    task automatic check_log(input int base, input string what);
        int n;
        int i;
        int bad;
        n   = vram_model_i.log_addr.size() - base;
        bad = 0;
        assert (n == exp_addr.size()) else begin
            log_error($sformatf("%s: %0d writes, expected %0d", what, n, exp_addr.size()));
            bad = 1;
        end
        for (i = 0; i < n && bad == 0; i++) begin
            assert (vram_model_i.log_addr[base + i] == exp_addr[i] &&
                    vram_model_i.log_data[base + i] == exp_data[i]) else begin
                log_error($sformatf("%s: write %0d is %0d/%h, expected %0d/%h", what, i,
                          vram_model_i.log_addr[base + i], vram_model_i.log_data[base + i],
                          exp_addr[i], exp_data[i]));
                bad = 1;
            end
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    // release valid, wait for the engine and compare the writes
    task automatic finish_lines(input int base, input string what);
        cmd_valid <= 1'b0;
        wait_idle(what);
        @(negedge clk);
        check_log(base, what);
        @(posedge clk);
    endtask

    task automatic run_clear(input logic [PIXEL_W-1:0] color);
        int base, c0, c_done, n, i, bad;
        check_short_cmd(cmd_word(OP_SET_COLOR, int'(color)), 1'b0, "set color");
        base = vram_model_i.log_addr.size();
        send_cmd(cmd_word(OP_CLEAR, 0), "clear");
        c0        = vram_model_i.cycle;
        cmd_valid <= 1'b0;
        wait_idle("clear");
        c_done = vram_model_i.cycle;
        @(negedge clk);
        n   = vram_model_i.log_addr.size() - base;
        bad = 0;
        assert (n == FB_PIXELS) else log_error($sformatf("clear: %0d writes", n));
        // first write three cycles after acceptance, then one per cycle
        for (i = 0; i < n && i < FB_PIXELS && bad == 0; i++) begin
            assert (vram_model_i.log_addr[base + i] == ADDR_W'(i) &&
                    vram_model_i.log_data[base + i] == color &&
                    vram_model_i.log_cycle[base + i] == c0 + 3 + i &&
                    vram_model_i.fb[i] == color) else begin
                log_error($sformatf("clear: bad write at index %0d", i));
                bad = 1;
            end
        end
        if (n > 0) begin
            assert (c_done == vram_model_i.log_cycle[base + n - 1] + 1)
                else log_error("clear: ready not back in the cycle after the last write");
        end
        @(posedge clk);
    endtask

    // on-screen octants, point, horizontal, vertical, then clipped lines
    int lines [16][4] = '{
        '{10, 10, 50, 20}, '{50, 20, 10, 10}, '{10, 10, 20, 50}, '{20, 50, 10, 10},
        '{10, 50, 50, 40}, '{50, 40, 10, 50}, '{10, 50, 20, 10}, '{20, 10, 10, 50},
        '{64, 64, 64, 64}, '{0, 5, 127, 5}, '{127, 0, 127, 127},
        '{-10, -5, 20, 30}, '{100, 120, 140, 135}, '{-16, 64, 143, 70},
        '{130, 130, 140, 140}, '{64, -16, 64, 10}
    };

    initial begin
        int i, base, op;
        int x0, y0, x1, y1;
        errors    = 0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        void'($urandom(SEED));
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i > 0) begin
                assert (vram.wr === 1'b0 && swap === 1'b0 && cmd_ready === 1'b0)
                    else log_error("wrong outputs during reset");
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        assert (vram.wr === 1'b0 && swap === 1'b0 && cmd_ready === 1'b1)
            else log_error("wrong outputs after reset");

        check_short_cmd(cmd_word(OP_SET_X0, 3), 1'b0, "set x0");
        check_short_cmd(cmd_word(OP_SET_Y1, -7), 1'b0, "set y1");
        run_clear(16'h1234);

        for (i = 0; i < 16; i++) begin
            base = vram_model_i.log_addr.size();
            queue_line(lines[i][0], lines[i][1], lines[i][2], lines[i][3],
                       PIXEL_W'(16'h0a00 + i));
            finish_lines(base, $sformatf("line %0d", i));
        end

        check_short_cmd(cmd_word(OP_SWAP, 0), 1'b1, "swap");
        for (op = 8; op < 16; op++) begin
            check_short_cmd(cmd_word(OP_W'(op), 'hffff), 1'b0, $sformatf("opcode %0d", op));
        end

        // random lines with valid held high throughout
        base = vram_model_i.log_addr.size();
        for (i = 0; i < RAND_LINES; i++) begin
            x0 = int'($urandom_range(159)) - 16;
            y0 = int'($urandom_range(159)) - 16;
            x1 = int'($urandom_range(159)) - 16;
            y1 = int'($urandom_range(159)) - 16;
            queue_line(x0, y0, x1, y1, PIXEL_W'($urandom));
        end
        finish_lines(base, "random lines");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* bench/vram_model.sv */
// vram model for the testbench
// keeps a shadow framebuffer and an ordered log of every write
`timescale 1ns/1ps

module vram_model
    import raster_pkg::*;
(
    input logic     clk,
    input vram_wr_t vram_i
);

    logic [PIXEL_W-1:0] fb [FB_PIXELS];
    logic [ADDR_W-1:0]  log_addr [$];
    logic [PIXEL_W-1:0] log_data [$];
    int                 log_cycle [$];
    int                 cycle = 0;

    // a write is logged at the edge that ends its cycle
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (vram_i.wr === 1'b1) begin
            log_addr.push_back(vram_i.addr);
            log_data.push_back(vram_i.data);
            log_cycle.push_back(cycle);
            if (vram_i.addr < FB_PIXELS) begin
                fb[vram_i.addr] <= vram_i.data;
            end
        end
    end

endmodule

/* sim.f */
source/raster_pkg.sv
source/cmd_fsm.sv
source/vertex_regs.sv
source/fill_counter.sv
source/line_stepper.sv
source/vram_writer.sv
source/raster_top.sv
bench/vram_model.sv
bench/raster_tb.sv

/* source/cmd_fsm.sv */
// command sequencer
// takes one command word while idle, decodes it and runs clear or line
// drawing until the worker block reports completion
`timescale 1ns/1ps

module cmd_fsm
    import raster_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 cmd_valid_i,
    input  logic [CMD_W-1:0]     cmd_data_i,
    output logic                 cmd_ready_o,
    input  logic                 fill_last_i,
    input  logic                 line_done_i,
    output op_e                  op_o,
    output logic [PAYLOAD_W-1:0] value_o,
    output logic                 load_o,
    output logic                 clear_start_o,
    output logic                 line_start_o,
    output logic                 swap_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_CLEAR,
        ST_LINE
    } state_e;

    state_e               state;
    op_e                  op_q;
    logic [PAYLOAD_W-1:0] value_q;
    logic                 clear_done_q;
    logic                 accept;
    logic                 exec;
    logic                 is_set;

    // no command is taken while in reset
    assign cmd_ready_o = (state == ST_IDLE) && !reset_i;
    assign accept      = cmd_valid_i && cmd_ready_o;
    assign exec        = (state == ST_EXEC);
    assign is_set      = op_q inside {[OP_SET_X0:OP_SET_COLOR]};

    assign op_o    = op_q;
    assign value_o = value_q;

    // one-cycle pulses, all in EXEC
    assign load_o        = exec && is_set;
    assign clear_start_o = exec && (op_q == OP_CLEAR);
    assign line_start_o  = exec && (op_q == OP_DRAW_LINE);
    assign swap_o        = exec && (op_q == OP_SWAP);

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op_e'(cmd_data_i[OP_POS +: OP_W]);
            value_q <= cmd_data_i[PAYLOAD_W-1:0];
        end
    end

    // last fill address is written one cycle later by vram_writer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            clear_done_q <= 1'b0;
        end else begin
            clear_done_q <= fill_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    case (op_q)
                        OP_CLEAR:     state <= ST_CLEAR;
                        OP_DRAW_LINE: state <= ST_LINE;
                        default:      state <= ST_IDLE;
                    endcase
                end
                ST_CLEAR: begin
                    if (clear_done_q) begin
                        state <= ST_IDLE;
                    end
                end
                ST_LINE: begin
                    if (line_done_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* source/fill_counter.sv */
// framebuffer sweep for clear
// walks every pixel address once, one per cycle, then stops
`timescale 1ns/1ps

module fill_counter
    import raster_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              start_i,
    output logic              fill_valid_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic              last_o
);

    logic              running;
    logic [ADDR_W-1:0] addr_q;

    assign fill_valid_o = running;
    assign addr_o       = addr_q;
    assign last_o       = running && (addr_q == ADDR_W'(FB_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            running <= 1'b0;
            addr_q  <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            addr_q  <= '0;
        end else if (running) begin
            // stop on the terminal count
            running <= !last_o;
            addr_q  <= addr_q + 1'b1;
        end
    end

endmodule

/* source/line_stepper.sv */
// bresenham line walker
// latches both endpoints on start and emits one point per cycle,
// flagging the end point with done
`timescale 1ns/1ps

module line_stepper
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      start_i,
    input  line_seg_t seg_i,
    output logic      pix_valid_o,
    output point_t    pix_o,
    output logic      done_o
);

    logic signed [ERR_W-1:0] span_x, span_y;
    logic signed [ERR_W-1:0] abs_x, abs_y;
    logic signed [ERR_W-1:0] dx, dy, err;
    logic signed [ERR_W-1:0] err2, add_x, add_y;
    logic                    step_x, step_y;
    logic                    neg_x, neg_y;
    logic                    busy;
    logic                    at_end;
    point_t                  cur, stop;

    assign span_x = ERR_W'(seg_i.p1.x) - ERR_W'(seg_i.p0.x);
    assign span_y = ERR_W'(seg_i.p1.y) - ERR_W'(seg_i.p0.y);
    assign abs_x  = span_x[ERR_W-1] ? -span_x : span_x;
    assign abs_y  = span_y[ERR_W-1] ? -span_y : span_y;

    // step decision from twice the error
    assign err2   = err <<< 1;
    assign step_x = (err2 >= dy);
    assign step_y = (err2 <= dx);
    assign add_x  = step_x ? dy : ERR_W'(0);
    assign add_y  = step_y ? dx : ERR_W'(0);

    assign at_end      = (cur == stop);
    assign pix_valid_o = busy;
    assign pix_o       = cur;
    assign done_o      = busy && at_end;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
        end else if (start_i) begin
            busy <= 1'b1;
        end else if (done_o) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            cur   <= seg_i.p0;
            stop  <= seg_i.p1;
            neg_x <= span_x[ERR_W-1];
            neg_y <= span_y[ERR_W-1];
            dx    <= abs_x;
            dy    <= -abs_y;
            err   <= abs_x - abs_y;
        end else if (busy && !at_end) begin
            if (step_x) begin
                cur.x <= neg_x ? cur.x - coord_t'(1) : cur.x + coord_t'(1);
            end
            if (step_y) begin
                cur.y <= neg_y ? cur.y - coord_t'(1) : cur.y + coord_t'(1);
            end
            err <= err + add_x + add_y;
        end
    end

endmodule

/* source/raster_pkg.sv */
// raster engine shared definitions
// framebuffer geometry, command word layout, opcodes and the structs
// that travel between the engine blocks
package raster_pkg;

    // framebuffer geometry
    localparam int FB_WIDTH  = 128;
    localparam int FB_HEIGHT = 128;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    localparam int COORD_W = 12;
    localparam int ADDR_W  = 16;
    localparam int PIXEL_W = 16;

    // command word layout
    localparam int CMD_W     = 32;
    localparam int OP_POS    = 28;
    localparam int OP_W      = 4;
    localparam int PAYLOAD_W = 16;

    // bresenham error term, wide enough for twice the largest span
    localparam int ERR_W = COORD_W + 4;

    // 8 to 15 are accepted and ignored
    typedef enum logic [OP_W-1:0] {
        OP_SET_X0    = 4'd0,
        OP_SET_Y0    = 4'd1,
        OP_SET_X1    = 4'd2,
        OP_SET_Y1    = 4'd3,
        OP_SET_COLOR = 4'd4,
        OP_CLEAR     = 4'd5,
        OP_DRAW_LINE = 4'd6,
        OP_SWAP      = 4'd7
    } op_e;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        point_t p0;
        point_t p1;
    } line_seg_t;

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [PIXEL_W-1:0] data;
    } vram_wr_t;

endpackage

/* source/raster_top.sv */
// line rasterizer top level
// command handshake in, one registered vram write per cycle out
`timescale 1ns/1ps

module raster_top
    import raster_pkg::*;
(
    input  logic             clk,
    input  logic             reset_i,
    input  logic             cmd_axis_tvalid_i,
    output logic             cmd_axis_tready_o,
    input  logic [CMD_W-1:0] cmd_axis_tdata_i,
    output vram_wr_t         vram_o,
    output logic             swap_o
);

    op_e                  op;
    logic [PAYLOAD_W-1:0] value;
    logic                 load;
    logic                 clear_start;
    logic                 line_start;
    logic                 fill_valid;
    logic [ADDR_W-1:0]    fill_addr;
    logic                 fill_last;
    line_seg_t            seg;
    logic [PIXEL_W-1:0]   color;
    logic                 pix_valid;
    point_t               pix;
    logic                 line_done;

    cmd_fsm cmd_fsm_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_valid_i   (cmd_axis_tvalid_i),
        .cmd_data_i    (cmd_axis_tdata_i),
        .cmd_ready_o   (cmd_axis_tready_o),
        .fill_last_i   (fill_last),
        .line_done_i   (line_done),
        .op_o          (op),
        .value_o       (value),
        .load_o        (load),
        .clear_start_o (clear_start),
        .line_start_o  (line_start),
        .swap_o        (swap_o)
    );

    vertex_regs vertex_regs_i (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (load),
        .op_i    (op),
        .value_i (value),
        .seg_o   (seg),
        .color_o (color)
    );

    fill_counter fill_counter_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (clear_start),
        .fill_valid_o (fill_valid),
        .addr_o       (fill_addr),
        .last_o       (fill_last)
    );

    line_stepper line_stepper_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (line_start),
        .seg_i       (seg),
        .pix_valid_o (pix_valid),
        .pix_o       (pix),
        .done_o      (line_done)
    );

    vram_writer vram_writer_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .fill_valid_i (fill_valid),
        .fill_addr_i  (fill_addr),
        .pix_valid_i  (pix_valid),
        .pix_i        (pix),
        .color_i      (color),
        .vram_o       (vram_o)
    );

endmodule

/* source/vertex_regs.sv */
// line endpoint and draw color registers
// written by the set commands, read by the line walker and the writer
`timescale 1ns/1ps

module vertex_regs
    import raster_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 load_i,
    input  op_e                  op_i,
    input  logic [PAYLOAD_W-1:0] value_i,
    output line_seg_t            seg_o,
    output logic [PIXEL_W-1:0]   color_o
);

    line_seg_t          seg_q;
    logic [PIXEL_W-1:0] color_q;
    coord_t             coord_in;

    // integer coordinate sits in the low bits of the payload
    assign coord_in = coord_t'(value_i[COORD_W-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            seg_q   <= '0;
            color_q <= '0;
        end else if (load_i) begin
            case (op_i)
                OP_SET_X0:    seg_q.p0.x <= coord_in;
                OP_SET_Y0:    seg_q.p0.y <= coord_in;
                OP_SET_X1:    seg_q.p1.x <= coord_in;
                OP_SET_Y1:    seg_q.p1.y <= coord_in;
                OP_SET_COLOR: color_q    <= value_i;
                default: begin
                end
            endcase
        end
    end

    assign seg_o   = seg_q;
    assign color_o = color_q;

endmodule

/* source/vram_writer.sv */
// vram write stage
// picks the fill address or the clipped line pixel address and
// registers the write toward the vram
`timescale 1ns/1ps

module vram_writer
    import raster_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fill_valid_i,
    input  logic [ADDR_W-1:0]  fill_addr_i,
    input  logic               pix_valid_i,
    input  point_t             pix_i,
    input  logic [PIXEL_W-1:0] color_i,
    output vram_wr_t           vram_o
);

    logic              on_screen;
    logic [ADDR_W-1:0] pix_addr;

    // clip to the framebuffer
    assign on_screen = (pix_i.x >= 0) && (pix_i.x < FB_WIDTH) &&
                       (pix_i.y >= 0) && (pix_i.y < FB_HEIGHT);

    // row-major, only meaningful when on screen
    assign pix_addr = ADDR_W'($unsigned(pix_i.y)) * ADDR_W'(FB_WIDTH) +
                      ADDR_W'($unsigned(pix_i.x));

    always_ff @(posedge clk) begin
        vram_o.data <= color_i;
        vram_o.addr <= fill_valid_i ? fill_addr_i : pix_addr;
        if (reset_i) begin
            vram_o.wr <= 1'b0;
        end else begin
            vram_o.wr <= fill_valid_i || (pix_valid_i && on_screen);
        end
    end

endmodule
